// ==== dv/vmul_vectors.svh ====
// Directed stimulus rows for the vector multiply lane testbench.
// columns: vs1, vs2, vs3, sew code, options {signed, high, widen, acc, neg}, expected data
// Expected values follow the slice, negate and accumulate rule by hand.

`ifndef VMUL_VECTORS_SVH
`define VMUL_VECTORS_SVH

typedef struct packed {
  logic [31:0] vs1;
  logic [31:0] vs2;
  logic [31:0] vs3;
  logic [1:0]  sew;
  logic [4:0]  opt;
  logic [31:0] exp_data;
} vec_row_t;

localparam int N_VEC = 24;

vec_row_t vec_table [N_VEC] = '{
  // low half, every width, signed and unsigned
  '{32'h000000fd, 32'h00000005, 32'h00000000, 2'd0, 5'b10000, 32'h000000f1},
  '{32'h123456c8, 32'hffffff03, 32'h00000000, 2'd0, 5'b00000, 32'h00000058},
  '{32'h0000ffff, 32'h0000ffff, 32'h00000000, 2'd1, 5'b00000, 32'h00000001},
  '{32'habcdfff9, 32'h00000006, 32'h00000000, 2'd1, 5'b10000, 32'h0000ffd6},
  '{32'hfffffffe, 32'h00000007, 32'h00000000, 2'd2, 5'b10000, 32'hfffffff2},
  '{32'h00000007, 32'h00000009, 32'h00000000, 2'd2, 5'b00000, 32'h0000003f},
  // high half, operands of mixed sign
  '{32'h00000080, 32'h0000007f, 32'h00000000, 2'd0, 5'b11000, 32'h000000c0},
  '{32'h00000080, 32'h0000007f, 32'h00000000, 2'd0, 5'b01000, 32'h0000003f},
  '{32'h00007fff, 32'h00008000, 32'h00000000, 2'd1, 5'b11000, 32'h0000c000},
  '{32'h0000ffff, 32'h0000ffff, 32'h00000000, 2'd1, 5'b01000, 32'h0000fffe},
  '{32'hfffffffe, 32'h00000007, 32'h00000000, 2'd2, 5'b11000, 32'hffffffff},
  '{32'hfffffffe, 32'h00000007, 32'h00000000, 2'd2, 5'b01000, 32'h00000006},
  '{32'h80000000, 32'h80000000, 32'h00000000, 2'd2, 5'b11000, 32'h40000000},
  // widening, upper bits beyond sew must be ignored
  '{32'h55555580, 32'haaaaaa05, 32'h00000000, 2'd0, 5'b10100, 32'hfffffd80},
  '{32'h12348000, 32'hffff0003, 32'h00000000, 2'd1, 5'b10100, 32'hfffe8000},
  '{32'h0000ffff, 32'h0000ffff, 32'h00000000, 2'd1, 5'b00100, 32'hfffe0001},
  // multiply-accumulate, plain and negated, with wraparound
  '{32'h00000003, 32'h00000004, 32'h00000100, 2'd1, 5'b10010, 32'h0000010c},
  '{32'h00000003, 32'h00000004, 32'h00000100, 2'd1, 5'b10011, 32'h000000f4},
  '{32'hffffffff, 32'h00000002, 32'h00000005, 2'd2, 5'b00010, 32'h00000003},
  '{32'h00000010, 32'h00000002, 32'h00000040, 2'd0, 5'b00011, 32'h00000020},
  '{32'h00007fff, 32'h00008000, 32'h00001000, 2'd1, 5'b11010, 32'h0000d000},
  // negate alone has no effect
  '{32'h000000fd, 32'h00000005, 32'h12345678, 2'd0, 5'b10001, 32'h000000f1},
  // reserved width code
  '{32'h00000005, 32'h00000007, 32'hdeadbeef, 2'd3, 5'b10011, 32'hdeadbeef},
  '{32'h00000005, 32'h00000007, 32'hdeadbeef, 2'd3, 5'b10000, 32'h00000000}
};

`endif

// ==== dv/vmul_tb.sv ====
// Testbench for the vector multiply lane top level.
// Runs the directed table, then 200 xorshift requests checked against
// a model of the slice, negate and accumulate rule. Every request also
// checks issue latency and result hold under random back-pressure.

`timescale 1ns/1ns

module vmul_tb;

  `include "vmul_vectors.svh"

  localparam int WAIT_LIMIT = 64;
  localparam int N_RANDOM   = 200;

  logic                              CLK;
  logic                              nRST;
  logic                              in_valid;
  logic                              in_ready;
  logic [vec_types_pkg::ELEM_W-1:0]  in_vs1;
  logic [vec_types_pkg::ELEM_W-1:0]  in_vs2;
  logic [vec_types_pkg::ELEM_W-1:0]  in_vs3;
  vec_types_pkg::sew_t               in_sew;
  logic                              in_signed;
  logic                              in_high;
  logic                              in_widen;
  logic                              in_acc;
  logic                              in_neg;
  logic                              out_valid;
  logic                              out_ready;
  logic [vec_types_pkg::ELEM_W-1:0]  out_data;

  int          errors;
  int          requests;
  logic        aborted;
  logic [31:0] rng;

  vmul_top dut_i (
    .CLK       (CLK),
    .nRST      (nRST),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_vs1    (in_vs1),
    .in_vs2    (in_vs2),
    .in_vs3    (in_vs3),
    .in_sew    (in_sew),
    .in_signed (in_signed),
    .in_high   (in_high),
    .in_widen  (in_widen),
    .in_acc    (in_acc),
    .in_neg    (in_neg),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_data  (out_data)
  );

  // 8 ns period
  always #4 CLK = ~CLK;

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // element of width w, sign-filled to 64 bits when sgn
  function automatic logic [63:0] extend_operand(input logic [31:0] v, input int w,
                                                 input logic sgn);
    logic [63:0] mask;
    logic [63:0] e;
    mask = (64'd1 << w) - 64'd1;
    e    = {32'd0, v} & mask;
    if (sgn && v[w-1]) begin
      e = e | ~mask;
    end
    return e;
  endfunction

  // opt bits: [4] signed, [3] high, [2] widen, [1] acc, [0] neg
  function automatic logic [31:0] model_wdata(input logic [31:0] vs1, input logic [31:0] vs2,
                                              input logic [31:0] vs3, input logic [1:0] sew,
                                              input logic [4:0] opt);
    int          w;
    logic [63:0] prod;
    logic [63:0] mask;
    logic [31:0] res;
    case (sew)
      2'd0:    w = 8;
      2'd1:    w = 16;
      2'd2:    w = 32;
      default: w = 0;
    endcase
    if (w == 0) begin
      res = '0;
    end else begin
      prod = extend_operand(vs2, w, opt[4]) * extend_operand(vs1, w, opt[4]);
      mask = (64'd1 << w) - 64'd1;
      if (opt[2]) begin
        res = prod[31:0];
      end else if (opt[3]) begin
        res = 32'((prod >> w) & mask);
      end else begin
        res = 32'(prod & mask);
      end
    end
    if (opt[1]) begin
      if (opt[0]) begin
        res = -res;
      end
      res = res + vs3;
    end
    return res;
  endfunction

  // one full transfer, hold = cycles of out_ready low once out_valid is up
  task automatic run_request(input vec_row_t row, input int hold);
    int          cyc;
    logic [31:0] held;
    requests++;
    in_vs1    = row.vs1;
    in_vs2    = row.vs2;
    in_vs3    = row.vs3;
    in_sew    = vec_types_pkg::sew_t'(row.sew);
    {in_signed, in_high, in_widen, in_acc, in_neg} = row.opt;
    in_valid  = 1'b1;
    out_ready = (hold == 0);
    cyc = 0;
    while (!in_ready) begin
      if (cyc >= WAIT_LIMIT) begin
        $display("timeout: in_ready stayed low for request %0d", requests);
        errors++;
        aborted = 1'b1;
        return;
      end
      @(negedge CLK);
      cyc++;
    end
    // accepting edge falls between these negedges
    @(negedge CLK);
    in_valid = 1'b0;
    // rising edges seen since the accepting edge
    cyc = 0;
    while (!out_valid) begin
      if (cyc >= WAIT_LIMIT) begin
        $display("timeout: out_valid never rose for request %0d", requests);
        errors++;
        aborted = 1'b1;
        return;
      end
      @(negedge CLK);
      cyc++;
    end
    if (cyc != mul_cfg_pkg::ISSUE_LATENCY) begin
      $display("error out_valid latency: got %h expected %h", cyc, mul_cfg_pkg::ISSUE_LATENCY);
      errors++;
    end
    if (out_data !== row.exp_data) begin
      $display("error out_data: got %h expected %h (request %0d)", out_data, row.exp_data,
               requests);
      errors++;
    end
    held = out_data;
    // back-pressure, result must sit still
    for (int i = 0; i < hold; i++) begin
      @(negedge CLK);
      if (out_valid !== 1'b1) begin
        $display("error out_valid: got %h expected %h", out_valid, 1'b1);
        errors++;
      end
      if (in_ready !== 1'b0) begin
        $display("error in_ready: got %h expected %h", in_ready, 1'b0);
        errors++;
      end
      if (out_data !== held) begin
        $display("error out_data: got %h expected %h (held)", out_data, held);
        errors++;
      end
    end
    out_ready = 1'b1;
    @(negedge CLK);
    if (out_valid !== 1'b0 || in_ready !== 1'b1) begin
      $display("error out_valid/in_ready: got %h expected %h", {out_valid, in_ready}, 2'b01);
      errors++;
    end
  endtask

  initial begin
    vec_row_t rnd;
    int       hold;
    errors    = 0;
    requests  = 0;
    aborted   = 1'b0;
    rng       = 32'h0f050228;
    CLK       = 1'b0;
    nRST      = 1'b0;
    in_valid  = 1'b0;
    in_vs1    = '0;
    in_vs2    = '0;
    in_vs3    = '0;
    in_sew    = vec_types_pkg::SEW8;
    in_signed = 1'b0;
    in_high   = 1'b0;
    in_widen  = 1'b0;
    in_acc    = 1'b0;
    in_neg    = 1'b0;
    out_ready = 1'b0;
    repeat (5) @(negedge CLK);
    nRST = 1'b1;
    @(negedge CLK);
    if (in_ready !== 1'b1 || out_valid !== 1'b0) begin
      $display("error in_ready/out_valid after reset: got %h expected %h",
               {in_ready, out_valid}, 2'b10);
      errors++;
    end

    for (int i = 0; i < N_VEC && !aborted; i++) begin
      rng  = xorshift32(rng);
      hold = int'(rng[7:0] % 8'd11);
      run_request(vec_table[i], hold);
    end

    for (int n = 0; n < N_RANDOM && !aborted; n++) begin
      rng      = xorshift32(rng);
      rnd.vs1  = rng;
      rng      = xorshift32(rng);
      rnd.vs2  = rng;
      rng      = xorshift32(rng);
      rnd.vs3  = rng;
      rng      = xorshift32(rng);
      rnd.sew  = rng[1:0];
      rnd.opt  = rng[6:2];
      rnd.exp_data = model_wdata(rnd.vs1, rnd.vs2, rnd.vs3, rnd.sew, rnd.opt);
      hold     = int'(rng[15:8] % 8'd11);
      run_request(rnd, hold);
    end

    $display("summary: %0d requests, %0d errors", requests, errors);
    if (errors == 0 && !aborted) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// ==== project.f ====
+incdir+dv
src/vec_types_pkg.sv
src/mul_cfg_pkg.sv
src/mul_lane_if.sv
src/seq_multiplier.sv
src/multiply_unit.sv
src/mul_issue.sv
src/vmul_top.sv
dv/vmul_tb.sv

// ==== run.sh ====
#!/bin/sh
# build the lane testbench with Verilator and run it; passes only on the pass line
verilator --binary --timing --assert -f project.f --top-module vmul_tb -o vmul_sim \
  && ./obj_dir/vmul_sim | tee /dev/stderr | grep -q -F "*** TEST PASSED ***" \
  || { echo "simulation did not pass"; exit 1; }

// ==== src/mul_cfg_pkg.sv ====
// Sizing of the iterative multiplier and the issue latency that follows.
// Compile after vec_types_pkg, since the iteration count derives from
// the element width.

package mul_cfg_pkg;

  // full product of two element-width magnitudes
  localparam int PROD_W = 2 * vec_types_pkg::ELEM_W;

  // multiplier bits retired per iteration
  localparam int MUL_BITS_PER_CYCLE = 2;

  // iterations per multiply, 16 for 32-bit elements
  localparam int MUL_CYCLES = vec_types_pkg::ELEM_W / MUL_BITS_PER_CYCLE;

  // width of the iteration counter
  localparam int MUL_CNT_W = $clog2(MUL_CYCLES);

  // accept edge to out_valid edge
  // start register + extension register + iterations
  localparam int ISSUE_LATENCY = MUL_CYCLES + 2;

endpackage

// ==== src/mul_issue.sv ====
// Issue front end for the vector multiply lane.
// Accepts one request over valid/ready, holds its fields on the lane
// interface and pulses start the cycle after the accept. The result is
// latched on done and offered over valid/ready until taken; no new
// request is accepted while a multiply runs or a result waits.

`timescale 1ns/1ns

module mul_issue (
  input  logic                              CLK,
  input  logic                              nRST,
  input  logic                              in_valid,
  output logic                              in_ready,
  input  logic [vec_types_pkg::ELEM_W-1:0]  in_vs1,
  input  logic [vec_types_pkg::ELEM_W-1:0]  in_vs2,
  input  logic [vec_types_pkg::ELEM_W-1:0]  in_vs3,
  input  vec_types_pkg::sew_t               in_sew,
  input  logic                              in_signed,
  input  logic                              in_high,
  input  logic                              in_widen,
  input  logic                              in_acc,
  input  logic                              in_neg,
  output logic                              out_valid,
  input  logic                              out_ready,
  output logic [vec_types_pkg::ELEM_W-1:0]  out_data,
  mul_lane_if.issue                         lane
);

  typedef enum logic [1:0] {
    IDLE,
    RUNNING,
    HOLDING
  } state_t;

  state_t                            state;
  state_t                            state_next;
  logic                              accept;
  logic                              start_q;

  // captured request
  logic [vec_types_pkg::ELEM_W-1:0]  vs1_q;
  logic [vec_types_pkg::ELEM_W-1:0]  vs2_q;
  logic [vec_types_pkg::ELEM_W-1:0]  vs3_q;
  vec_types_pkg::sew_t               sew_q;
  logic                              signed_q;
  logic                              high_q;
  logic                              widen_q;
  logic                              acc_q;
  logic                              neg_q;

  // result waiting for the consumer
  logic [vec_types_pkg::ELEM_W-1:0]  res_q;

  assign in_ready  = (state == IDLE);
  assign out_valid = (state == HOLDING);
  assign out_data  = res_q;
  assign accept    = in_valid && in_ready;

  always_comb begin
    state_next = state;
    case (state)
      IDLE:    if (accept)    state_next = RUNNING;
      RUNNING: if (lane.done) state_next = HOLDING;
      HOLDING: if (out_ready) state_next = IDLE;
      default: state_next = IDLE;
    endcase
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state   <= IDLE;
      start_q <= 1'b0;
    end else begin
      state   <= state_next;
      // single pulse, accept only happens in idle
      start_q <= accept;
    end
  end

  always_ff @(posedge CLK) begin
    if (accept) begin
      vs1_q    <= in_vs1;
      vs2_q    <= in_vs2;
      vs3_q    <= in_vs3;
      sew_q    <= in_sew;
      signed_q <= in_signed;
      high_q   <= in_high;
      widen_q  <= in_widen;
      acc_q    <= in_acc;
      neg_q    <= in_neg;
    end
    if (lane.done) begin
      res_q <= lane.wdata;
    end
  end

  // request fields stay put until the next accept
  assign lane.start      = start_q;
  assign lane.vs1_data   = vs1_q;
  assign lane.vs2_data   = vs2_q;
  assign lane.vs3_data   = vs3_q;
  assign lane.sew        = sew_q;
  assign lane.is_signed  = signed_q;
  assign lane.high_low   = high_q;
  assign lane.widen      = widen_q;
  assign lane.accumulate = acc_q;
  assign lane.negate     = neg_q;

  a_out_stable: assert property (
    @(posedge CLK) disable iff (!nRST)
    (out_valid && !out_ready) |=> (out_valid && $stable(out_data))
  ) else $error("mul_issue: out_data changed under back-pressure");

  // end-to-end latency through the multiply unit
  a_issue_latency: assert property (
    @(posedge CLK) disable iff (!nRST)
    accept |=> !out_valid [*mul_cfg_pkg::ISSUE_LATENCY] ##1 out_valid
  ) else $error("mul_issue: out_valid not at the expected latency");

  a_start_to_done: assert property (
    @(posedge CLK) disable iff (!nRST)
    lane.start |-> ##(mul_cfg_pkg::MUL_CYCLES + 1) lane.done
  ) else $error("mul_issue: done not at the expected cycle after start");

endmodule

// ==== src/mul_lane_if.sv ====
// Connection between the issue front end and the multiply unit.
// The issue side owns the request, the unit side returns the result.
// start is a single-cycle pulse while the unit is idle; operands and
// options hold until done, which pulses for one cycle with wdata.

`timescale 1ns/1ns

interface mul_lane_if;

  // request, driven by the issue block
  logic                                start;
  logic [vec_types_pkg::ELEM_W-1:0]    vs1_data;
  logic [vec_types_pkg::ELEM_W-1:0]    vs2_data;
  logic [vec_types_pkg::ELEM_W-1:0]    vs3_data;
  vec_types_pkg::sew_t                 sew;
  logic                                is_signed;
  logic                                high_low;
  logic                                widen;
  logic                                accumulate;
  logic                                negate;

  // response, driven by the multiply unit
  logic                                done;
  logic [vec_types_pkg::ELEM_W-1:0]    wdata;

  modport issue (
    output start, vs1_data, vs2_data, vs3_data, sew,
    output is_signed, high_low, widen, accumulate, negate,
    input  done, wdata
  );

  modport mu (
    input  start, vs1_data, vs2_data, vs3_data, sew,
    input  is_signed, high_low, widen, accumulate, negate,
    output done, wdata
  );

endinterface

// ==== src/multiply_unit.sv ====
// Vector multiply unit for one lane.
// Extends vs1/vs2 from the element width into a register stage on start,
// runs the sequential multiplier, then picks the product slice,
// optionally negates it and adds vs3. done and wdata follow finished
// in the same cycle, with no register after the product.

`timescale 1ns/1ns

module multiply_unit (
  input  logic   CLK,
  input  logic   nRST,
  mul_lane_if.mu mif
);

  logic                                  start_q;
  logic                                  pending;

  // extended operands
  logic signed [vec_types_pkg::ELEM_W:0] op_a;
  logic signed [vec_types_pkg::ELEM_W:0] op_b;

  logic                                  finished;
  logic [mul_cfg_pkg::PROD_W-1:0]        product;

  logic                                  sew_ok;
  logic [vec_types_pkg::ELEM_W-1:0]      half_hi;
  logic [vec_types_pkg::ELEM_W-1:0]      half_lo;
  logic [vec_types_pkg::ELEM_W-1:0]      slice;
  logic [vec_types_pkg::ELEM_W-1:0]      acc_term;

  // sign or zero extension from the selected element width
  function automatic logic signed [vec_types_pkg::ELEM_W:0] extend(
    input logic [vec_types_pkg::ELEM_W-1:0] v,
    input vec_types_pkg::sew_t              sew,
    input logic                             sgn
  );
    logic signed [vec_types_pkg::ELEM_W:0] r;
    case (sew)
      vec_types_pkg::SEW8:  r = {{25{sgn & v[7]}}, v[7:0]};
      vec_types_pkg::SEW16: r = {{17{sgn & v[15]}}, v[15:0]};
      vec_types_pkg::SEW32: r = {sgn & v[31], v};
      default:              r = '0;
    endcase
    return r;
  endfunction

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      start_q <= 1'b0;
      pending <= 1'b0;
    end else begin
      start_q <= mif.start;
      // open from start until the result leaves
      if (mif.start) begin
        pending <= 1'b1;
      end else if (finished) begin
        pending <= 1'b0;
      end
    end
  end

  // vs2 is the multiplicand, vs1 the multiplier
  always_ff @(posedge CLK) begin
    if (mif.start) begin
      op_a <= extend(mif.vs2_data, mif.sew, mif.is_signed);
      op_b <= extend(mif.vs1_data, mif.sew, mif.is_signed);
    end
  end

  seq_multiplier mult_i (
    .CLK          (CLK),
    .nRST         (nRST),
    .start        (start_q),
    .multiplicand (op_a),
    .multiplier   (op_b),
    .finished     (finished),
    .product      (product)
  );

  // sew-wide halves of the product, zero-extended
  always_comb begin
    sew_ok  = 1'b1;
    half_hi = '0;
    half_lo = '0;
    case (mif.sew)
      vec_types_pkg::SEW8: begin
        half_hi[7:0] = product[15:8];
        half_lo[7:0] = product[7:0];
      end
      vec_types_pkg::SEW16: begin
        half_hi[15:0] = product[31:16];
        half_lo[15:0] = product[15:0];
      end
      vec_types_pkg::SEW32: begin
        half_hi = product[63:32];
        half_lo = product[31:0];
      end
      default: begin
        sew_ok = 1'b0;
      end
    endcase

    // reserved width gives zero, widening takes the low word
    if (!sew_ok) begin
      slice = '0;
    end else if (mif.widen) begin
      slice = product[vec_types_pkg::ELEM_W-1:0];
    end else if (mif.high_low) begin
      slice = half_hi;
    end else begin
      slice = half_lo;
    end
  end

  // negate only matters on the accumulate path
  assign acc_term  = mif.negate ? -slice : slice;
  assign mif.wdata = mif.accumulate ? acc_term + mif.vs3_data : slice;
  assign mif.done  = finished;

  a_done_after_start: assert property (
    @(posedge CLK) disable iff (!nRST) mif.done |-> pending
  ) else $error("multiply_unit: done without an open request");

endmodule

// ==== src/seq_multiplier.sv ====
// Iterative shift-add multiplier, 33-bit signed operands to a 64-bit product.
// Operands are loaded on start as magnitudes; two multiplier bits are
// retired per cycle. The last iteration is resolved combinationally and
// the sign is applied there, so finished and product appear together on
// the 16th cycle after the load.

`timescale 1ns/1ns

module seq_multiplier (
  input  logic                                    CLK,
  input  logic                                    nRST,
  input  logic                                    start,
  input  logic signed [vec_types_pkg::ELEM_W:0]   multiplicand,
  input  logic signed [vec_types_pkg::ELEM_W:0]   multiplier,
  output logic                                    finished,
  output logic [mul_cfg_pkg::PROD_W-1:0]          product
);

  logic                                  busy;
  logic [mul_cfg_pkg::MUL_CNT_W-1:0]     iter_cnt;
  logic                                  last_iter;

  // operand magnitudes, bit 32 stays clear for 32-bit sources
  logic [vec_types_pkg::ELEM_W:0]        mcand_mag;
  logic [vec_types_pkg::ELEM_W:0]        mplier_mag;

  // working state
  logic [mul_cfg_pkg::PROD_W-1:0]        mcand_sh;
  logic [vec_types_pkg::ELEM_W:0]        mplier_sh;
  logic [mul_cfg_pkg::PROD_W-1:0]        acc;
  logic                                  neg_q;

  logic [mul_cfg_pkg::PROD_W-1:0]        partial;
  logic [mul_cfg_pkg::PROD_W-1:0]        acc_next;

  assign mcand_mag  = multiplicand[vec_types_pkg::ELEM_W] ? -multiplicand : multiplicand;
  assign mplier_mag = multiplier[vec_types_pkg::ELEM_W] ? -multiplier : multiplier;

  // partial product for the low multiplier bits of this step
  always_comb begin
    partial = '0;
    for (int i = 0; i < mul_cfg_pkg::MUL_BITS_PER_CYCLE; i++) begin
      if (mplier_sh[i]) begin
        partial = partial + (mcand_sh << i);
      end
    end
  end

  assign acc_next  = acc + partial;
  assign last_iter = busy &&
                     (iter_cnt == mul_cfg_pkg::MUL_CNT_W'(mul_cfg_pkg::MUL_CYCLES - 1));

  // sign goes on with the final partial
  assign finished = last_iter;
  assign product  = neg_q ? -acc_next : acc_next;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      busy     <= 1'b0;
      iter_cnt <= '0;
    end else if (start) begin
      busy     <= 1'b1;
      iter_cnt <= '0;
    end else if (busy) begin
      busy     <= !last_iter;
      iter_cnt <= iter_cnt + 1'b1;
    end
  end

  always_ff @(posedge CLK) begin
    if (start) begin
      mcand_sh  <= {{(mul_cfg_pkg::PROD_W - vec_types_pkg::ELEM_W - 1){1'b0}}, mcand_mag};
      mplier_sh <= mplier_mag;
      acc       <= '0;
      neg_q     <= multiplicand[vec_types_pkg::ELEM_W] ^ multiplier[vec_types_pkg::ELEM_W];
    end else if (busy) begin
      acc       <= acc_next;
      mcand_sh  <= mcand_sh << mul_cfg_pkg::MUL_BITS_PER_CYCLE;
      mplier_sh <= mplier_sh >> mul_cfg_pkg::MUL_BITS_PER_CYCLE;
    end
  end

  // a new load would corrupt the running product
  a_no_start_while_busy: assert property (
    @(posedge CLK) disable iff (!nRST) busy |-> !start
  ) else $error("seq_multiplier: start while iterations remain");

endmodule

// ==== src/vec_types_pkg.sv ====
// Element-level definitions for the vector multiply lane.
// Shared by the RTL and the testbench. Files refer to these by scoped
// names, e.g. vec_types_pkg::SEW16, and never import the package.

package vec_types_pkg;

  // element data width, one lane of an RV32 vector register
  localparam int ELEM_W = 32;

  // selected element width, vsew encoding
  // code 2'b11 is reserved and yields a zero product slice
  typedef enum logic [1:0] {
    SEW8  = 2'b00,
    SEW16 = 2'b01,
    SEW32 = 2'b10
  } sew_t;

  // request option bits, carried as separate single-bit fields
  //   is_signed   operands sign-extended from sew, else zero-extended
  //   high_low    1 selects the upper sew half of the product
  //   widen       return the low 32 product bits instead of a sew slice
  //   accumulate  add vs3 to the selected slice
  //   negate      negate the slice before the add, only with accumulate

endpackage

// ==== src/vmul_top.sv ====
// Top level of the vector multiply lane.
// Request in and write data out over valid/ready with plain ports;
// the issue block and the multiply unit meet on a lane interface.

`timescale 1ns/1ns

module vmul_top (
  input  logic                              CLK,
  input  logic                              nRST,
  input  logic                              in_valid,
  output logic                              in_ready,
  input  logic [vec_types_pkg::ELEM_W-1:0]  in_vs1,
  input  logic [vec_types_pkg::ELEM_W-1:0]  in_vs2,
  input  logic [vec_types_pkg::ELEM_W-1:0]  in_vs3,
  input  vec_types_pkg::sew_t               in_sew,
  input  logic                              in_signed,
  input  logic                              in_high,
  input  logic                              in_widen,
  input  logic                              in_acc,
  input  logic                              in_neg,
  output logic                              out_valid,
  input  logic                              out_ready,
  output logic [vec_types_pkg::ELEM_W-1:0]  out_data
);

  mul_lane_if lane_if ();

  mul_issue issue_i (
    .CLK       (CLK),
    .nRST      (nRST),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_vs1    (in_vs1),
    .in_vs2    (in_vs2),
    .in_vs3    (in_vs3),
    .in_sew    (in_sew),
    .in_signed (in_signed),
    .in_high   (in_high),
    .in_widen  (in_widen),
    .in_acc    (in_acc),
    .in_neg    (in_neg),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_data  (out_data),
    .lane      (lane_if)
  );

  multiply_unit mu_i (
    .CLK  (CLK),
    .nRST (nRST),
    .mif  (lane_if)
  );

endmodule
